//--- alu.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module alu import cpuPkg::*; (
  input  logic [`CPU_WORD_WIDTH-1:0] srcA,
  input  logic [`CPU_WORD_WIDTH-1:0] srcB,
  input  aluOp                       op,
  output logic [`CPU_WORD_WIDTH-1:0] result,
  output logic                       zero
);

  always_comb begin
    case (op)
      aluAdd: result = srcA + srcB;
      aluSub: result = srcA - srcB;
      aluOr:  result = srcA | srcB;
      aluAnd: result = srcA & srcB;
      aluXor: result = srcA ^ srcB;
      // Signed compare, result is 1 or 0
      aluSlt: begin
        if ($signed(srcA) < $signed(srcB)) begin
          result = `CPU_WORD_WIDTH'(1);
        end else begin
          result = '0;
        end
      end
      default: result = '0;
    endcase
  end

  // Used by BEQ after a subtract
  assign zero = (result == '0);

endmodule

//--- controlFsm.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module controlFsm import cpuPkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`CPU_OPCODE_WIDTH-1:0]  opcode,
  output logic                          pcWrite,
  output logic                          pcWriteCond,
  output logic                          irWrite,
  output logic                          regWrite,
  output logic                          dataWrite,
  output logic                          aluSrcA,
  output logic                          regReadSel,
  output logic                          memToReg,
  output aluSrcBSel                     aluSrcB,
  output pcSourceSel                    pcSource,
  output aluOp                          aluSel
);

  cpuState    state;
  cpuState    stateNext;
  logic       pcWriteNext;
  logic       pcWriteCondNext;
  logic       irWriteNext;
  logic       regWriteNext;
  logic       dataWriteNext;
  logic       aluSrcANext;
  logic       regReadSelNext;
  logic       memToRegNext;
  aluSrcBSel  aluSrcBNext;
  pcSourceSel pcSourceNext;
  aluOp       aluSelNext;

  // Controls for the state being entered, registered on the same edge
  always_comb begin
    stateNext       = state;
    pcWriteNext     = 1'b0;
    pcWriteCondNext = 1'b0;
    irWriteNext     = 1'b0;
    regWriteNext    = 1'b0;
    dataWriteNext   = 1'b0;
    aluSrcANext     = 1'b0;
    regReadSelNext  = 1'b0;
    memToRegNext    = 1'b0;
    aluSrcBNext     = srcBOne;
    pcSourceNext    = pcFromAlu;
    aluSelNext      = aluAdd;

    case (state)
      resetState: stateNext = fetch;
      fetch: begin
        stateNext = decode;
        // Branch target PC+1+imm goes into ALU-out while decoding
        aluSrcBNext = srcBSignImm;
      end
      decode: begin
        // NOP and undefined opcodes fall back to fetch
        stateNext = fetch;
        case (opClass'(opcode[5:4]))
          classReg: begin
            case (opcode[3:0])
              aluAdd, aluSub, aluOr, aluAnd, aluXor, aluSlt: begin
                stateNext   = executeReg;
                aluSrcANext = 1'b1;
                aluSrcBNext = srcBReg;
                aluSelNext  = aluOp'(opcode[3:0]);
              end
              default: stateNext = fetch;
            endcase
          end
          classImm: begin
            case (opcode[3:0])
              aluAdd, aluSub, aluSlt: begin
                stateNext   = executeImmSigned;
                aluSrcANext = 1'b1;
                aluSrcBNext = srcBSignImm;
                aluSelNext  = aluOp'(opcode[3:0]);
              end
              aluOr, aluAnd, aluXor: begin
                stateNext   = executeImmZero;
                aluSrcANext = 1'b1;
                aluSrcBNext = srcBZeroImm;
                aluSelNext  = aluOp'(opcode[3:0]);
              end
              codeLoad: stateNext = loadRead;
              codeStore: begin
                stateNext      = storeRead;
                regReadSelNext = 1'b1;
              end
              default: stateNext = fetch;
            endcase
          end
          classBranch: begin
            if (opcode[3:0] == codeBranch) begin
              stateNext      = branchRead;
              regReadSelNext = 1'b1;
              aluSrcBNext    = srcBSignImm;
            end
          end
          default: begin
            if (opcode[3:0] == codeJump) begin
              stateNext    = jumpDone;
              pcWriteNext  = 1'b1;
              pcSourceNext = pcFromJump;
            end
          end
        endcase
      end
      executeReg, executeImmSigned, executeImmZero: begin
        stateNext    = aluWriteBack;
        regWriteNext = 1'b1;
      end
      loadRead: begin
        stateNext    = loadWriteBack;
        regWriteNext = 1'b1;
        memToRegNext = 1'b1;
      end
      storeRead: begin
        stateNext     = storeWrite;
        dataWriteNext = 1'b1;
      end
      branchRead: begin
        // Compare rs against rd, target already waits in ALU-out
        stateNext       = branchDone;
        pcWriteCondNext = 1'b1;
        pcSourceNext    = pcFromAluOut;
        aluSelNext      = aluSub;
        aluSrcANext     = 1'b1;
        aluSrcBNext     = srcBReg;
      end
      default: stateNext = fetch;
    endcase

    // Fetch loads IR and steps PC to PC+1
    if (stateNext == fetch) begin
      pcWriteNext = 1'b1;
      irWriteNext = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= resetState;
      pcWrite     <= 1'b0;
      pcWriteCond <= 1'b0;
      irWrite     <= 1'b0;
      regWrite    <= 1'b0;
      dataWrite   <= 1'b0;
      aluSrcA     <= 1'b0;
      regReadSel  <= 1'b0;
      memToReg    <= 1'b0;
      aluSrcB     <= srcBOne;
      pcSource    <= pcFromAlu;
      aluSel      <= aluAdd;
    end else begin
      state       <= stateNext;
      pcWrite     <= pcWriteNext;
      pcWriteCond <= pcWriteCondNext;
      irWrite     <= irWriteNext;
      regWrite    <= regWriteNext;
      dataWrite   <= dataWriteNext;
      aluSrcA     <= aluSrcANext;
      regReadSel  <= regReadSelNext;
      memToReg    <= memToRegNext;
      aluSrcB     <= aluSrcBNext;
      pcSource    <= pcSourceNext;
      aluSel      <= aluSelNext;
    end
  end

endmodule

//--- cpuPkg.sv
package cpuPkg;

  // Control FSM states
  typedef enum logic [3:0] {
    resetState,
    fetch,
    decode,
    executeReg,
    executeImmSigned,
    executeImmZero,
    aluWriteBack,
    loadRead,
    loadWriteBack,
    storeRead,
    storeWrite,
    branchRead,
    branchDone,
    jumpDone
  } cpuState;

  // Opcode bits 5:4
  typedef enum logic [1:0] {classJumpNop, classReg, classBranch, classImm} opClass;

  // Opcode bits 3:0 double as the ALU operation
  typedef enum logic [3:0] {
    aluAdd = 4'd2,
    aluSub = 4'd3,
    aluOr  = 4'd4,
    aluAnd = 4'd5,
    aluXor = 4'd6,
    aluSlt = 4'd7
  } aluOp;

  // Low opcode codes that are not ALU operations
  localparam logic [3:0] codeJump   = 4'd1;
  localparam logic [3:0] codeBranch = 4'd0;
  localparam logic [3:0] codeLoad   = 4'd11;
  localparam logic [3:0] codeStore  = 4'd12;

  typedef enum logic [1:0] {srcBReg, srcBOne, srcBSignImm, srcBZeroImm} aluSrcBSel;

  typedef enum logic [1:0] {pcFromAlu, pcFromAluOut, pcFromJump} pcSourceSel;

endpackage

//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address word
`define CPU_WORD_WIDTH 32

// Register file geometry
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_WIDTH 5

// Instruction fields
`define CPU_IMM_WIDTH 16
`define CPU_OPCODE_WIDTH 6

// Data memory is addressed by the low immediate bits
`define CPU_DATA_ADDR_WIDTH 9

`endif

//--- datapath.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module datapath import cpuPkg::*; (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              pcWrite,
  input  logic                              pcWriteCond,
  input  logic                              irWrite,
  input  logic                              regWrite,
  input  logic                              aluSrcA,
  input  logic                              regReadSel,
  input  logic                              memToReg,
  input  aluSrcBSel                         aluSrcB,
  input  pcSourceSel                        pcSource,
  input  aluOp                              aluSel,
  input  logic [`CPU_WORD_WIDTH-1:0]        instr,
  input  logic [`CPU_WORD_WIDTH-1:0]        dataReadData,
  output logic [`CPU_OPCODE_WIDTH-1:0]      opcode,
  output logic [`CPU_WORD_WIDTH-1:0]        instrAddr,
  output logic [`CPU_DATA_ADDR_WIDTH-1:0]   dataAddr,
  output logic [`CPU_WORD_WIDTH-1:0]        dataWriteData
);

  logic [`CPU_WORD_WIDTH-1:0]     pc;
  logic [`CPU_WORD_WIDTH-1:0]     ir;
  logic [`CPU_WORD_WIDTH-1:0]     aReg;
  logic [`CPU_WORD_WIDTH-1:0]     bReg;
  logic [`CPU_WORD_WIDTH-1:0]     aluOut;
  logic [`CPU_WORD_WIDTH-1:0]     mdr;
  logic [`CPU_WORD_WIDTH-1:0]     pcNext;
  logic [`CPU_IMM_WIDTH-1:0]      imm;
  logic [`CPU_WORD_WIDTH-1:0]     signImm;
  logic [`CPU_WORD_WIDTH-1:0]     zeroImm;
  logic [`CPU_WORD_WIDTH-1:0]     jumpTarget;
  logic [`CPU_REG_ADDR_WIDTH-1:0] readAddrB;
  logic [`CPU_WORD_WIDTH-1:0]     readDataA;
  logic [`CPU_WORD_WIDTH-1:0]     readDataB;
  logic [`CPU_WORD_WIDTH-1:0]     writeData;
  logic [`CPU_WORD_WIDTH-1:0]     aluA;
  logic [`CPU_WORD_WIDTH-1:0]     aluB;
  logic [`CPU_WORD_WIDTH-1:0]     aluResult;
  logic                           aluZero;
  logic                           pcEnable;

  // Instruction fields
  assign opcode = ir[31:26];
  assign imm    = ir[`CPU_IMM_WIDTH-1:0];

  assign signImm = {{(`CPU_WORD_WIDTH-`CPU_IMM_WIDTH){imm[`CPU_IMM_WIDTH-1]}}, imm};
  assign zeroImm = {{(`CPU_WORD_WIDTH-`CPU_IMM_WIDTH){1'b0}}, imm};

  // PC already holds PC+1 when J completes
  assign jumpTarget = pc + signImm;

  // Port B reads rt for ALU work, rd for branch and store
  assign readAddrB = regReadSel ? ir[25:21] : ir[15:11];
  assign writeData = memToReg ? mdr : aluOut;

  registerFile registerFile_i (
    .clk         (clk),
    .reset       (reset),
    .readAddrA   (ir[20:16]),
    .readAddrB   (readAddrB),
    .writeAddr   (ir[25:21]),
    .writeData   (writeData),
    .writeEnable (regWrite),
    .readDataA   (readDataA),
    .readDataB   (readDataB)
  );

  assign aluA = aluSrcA ? aReg : pc;

  always_comb begin
    case (aluSrcB)
      srcBReg:     aluB = bReg;
      srcBOne:     aluB = `CPU_WORD_WIDTH'(1);
      srcBSignImm: aluB = signImm;
      default:     aluB = zeroImm;
    endcase
  end

  alu alu_i (
    .srcA   (aluA),
    .srcB   (aluB),
    .op     (aluSel),
    .result (aluResult),
    .zero   (aluZero)
  );

  always_comb begin
    case (pcSource)
      pcFromAluOut: pcNext = aluOut;
      pcFromJump:   pcNext = jumpTarget;
      default:      pcNext = aluResult;
    endcase
  end

  // Branch only writes when rs equals rd
  assign pcEnable = pcWrite | (pcWriteCond & aluZero);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      ir <= '0;
    end else begin
      if (pcEnable) begin
        pc <= pcNext;
      end
      if (irWrite) begin
        ir <= instr;
      end
    end
  end

  // Working registers reload every cycle
  always_ff @(posedge clk) begin
    aReg   <= readDataA;
    bReg   <= readDataB;
    aluOut <= aluResult;
    mdr    <= dataReadData;
  end

  assign instrAddr     = pc;
  assign dataAddr      = imm[`CPU_DATA_ADDR_WIDTH-1:0];
  assign dataWriteData = bReg;

endmodule

//--- multiCycleCpu.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module multiCycleCpu import cpuPkg::*; (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [`CPU_WORD_WIDTH-1:0]        instr,
  input  logic [`CPU_WORD_WIDTH-1:0]        dataReadData,
  output logic [`CPU_WORD_WIDTH-1:0]        instrAddr,
  output logic [`CPU_DATA_ADDR_WIDTH-1:0]   dataAddr,
  output logic [`CPU_WORD_WIDTH-1:0]        dataWriteData,
  output logic                              dataWrite
);

  logic                          pcWrite;
  logic                          pcWriteCond;
  logic                          irWrite;
  logic                          regWrite;
  logic                          aluSrcA;
  logic                          regReadSel;
  logic                          memToReg;
  aluSrcBSel                     aluSrcB;
  pcSourceSel                    pcSource;
  aluOp                          aluSel;
  logic [`CPU_OPCODE_WIDTH-1:0]  opcode;

  controlFsm controlFsm_i (
    .clk         (clk),
    .reset       (reset),
    .opcode      (opcode),
    .pcWrite     (pcWrite),
    .pcWriteCond (pcWriteCond),
    .irWrite     (irWrite),
    .regWrite    (regWrite),
    .dataWrite   (dataWrite),
    .aluSrcA     (aluSrcA),
    .regReadSel  (regReadSel),
    .memToReg    (memToReg),
    .aluSrcB     (aluSrcB),
    .pcSource    (pcSource),
    .aluSel      (aluSel)
  );

  datapath datapath_i (
    .clk           (clk),
    .reset         (reset),
    .pcWrite       (pcWrite),
    .pcWriteCond   (pcWriteCond),
    .irWrite       (irWrite),
    .regWrite      (regWrite),
    .aluSrcA       (aluSrcA),
    .regReadSel    (regReadSel),
    .memToReg      (memToReg),
    .aluSrcB       (aluSrcB),
    .pcSource      (pcSource),
    .aluSel        (aluSel),
    .instr         (instr),
    .dataReadData  (dataReadData),
    .opcode        (opcode),
    .instrAddr     (instrAddr),
    .dataAddr      (dataAddr),
    .dataWriteData (dataWriteData)
  );

endmodule

//--- multiCycleCpuTb.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module multiCycleCpuTb;

  localparam int periodNs = 40;
  localparam int dataWords = 1 << `CPU_DATA_ADDR_WIDTH;

  // Opcodes from class bits 5:4 and code bits 3:0
  localparam logic [5:0] opSlt  = 6'h17;
  localparam logic [5:0] opAddi = 6'h32;
  localparam logic [5:0] opLwi  = 6'h3B;
  localparam logic [5:0] opSwi  = 6'h3C;
  localparam logic [5:0] opBeq  = 6'h20;
  localparam logic [5:0] opJ    = 6'h01;

  // Immediates for ADDI, SUBI, ORI, ANDI, XORI, SLTI from the low end
  localparam logic [6*16-1:0] immTable =
    {16'hFF00, 16'hFFFF, 16'hF0F0, 16'h8F0F, 16'hFFF0, 16'h8123};
  localparam logic [15:0] skippedAddr = 16'h0063;

  logic                            clk;
  logic                            reset;
  logic [`CPU_WORD_WIDTH-1:0]      instr;
  logic [`CPU_WORD_WIDTH-1:0]      dataReadData;
  logic [`CPU_WORD_WIDTH-1:0]      instrAddr;
  logic [`CPU_DATA_ADDR_WIDTH-1:0] dataAddr;
  logic [`CPU_WORD_WIDTH-1:0]      dataWriteData;
  logic                            dataWrite;

  logic [`CPU_WORD_WIDTH-1:0]      progMem [64];
  logic [`CPU_WORD_WIDTH-1:0]      dataMem [dataWords];
  logic [`CPU_DATA_ADDR_WIDTH-1:0] expAddrList [64];
  logic [`CPU_WORD_WIDTH-1:0]      expDataList [64];
  int                              expGapList [64];
  logic [`CPU_DATA_ADDR_WIDTH-1:0] expAddr;
  logic [`CPU_WORD_WIDTH-1:0]      expData;
  int                              expGap;

  int   progLen = 0;
  int   haltAddr = 0;
  int   expCount = 0;
  int   storeIndex = 0;
  int   cycleCount = 0;
  int   lastStoreCycle = 0;
  logic resetDelayed = 1'b1;
  logic haltSeen = 1'b0;
  int   resetErrors = 0;
  int   storeErrors = 0;
  int   timingErrors = 0;
  int   countErrors = 0;

  tbClock #(.periodNs(periodNs), .resetCycles(8)) tbClock_i (
    .clk   (clk),
    .reset (reset)
  );

  multiCycleCpu multiCycleCpu_i (
    .clk           (clk),
    .reset         (reset),
    .instr         (instr),
    .dataReadData  (dataReadData),
    .instrAddr     (instrAddr),
    .dataAddr      (dataAddr),
    .dataWriteData (dataWriteData),
    .dataWrite     (dataWrite)
  );

  // Both memories answer in the same cycle
  assign instr        = (instrAddr < 64) ? progMem[instrAddr[5:0]] : '0;
  assign dataReadData = dataMem[dataAddr];

  always @(posedge clk) begin
    if (dataWrite === 1'b1) begin
      dataMem[dataAddr] <= dataWriteData;
    end
  end

  always_comb begin
    expAddr = expAddrList[storeIndex];
    expData = expDataList[storeIndex];
    expGap  = expGapList[storeIndex];
  end

  // Store progress and cycle bookkeeping
  always @(posedge clk) begin
    cycleCount   <= cycleCount + 1;
    resetDelayed <= reset;
    if (!reset && dataWrite === 1'b1) begin
      storeIndex     <= storeIndex + 1;
      lastStoreCycle <= cycleCount;
    end
    if (!reset && instrAddr == haltAddr + 1) begin
      haltSeen <= 1'b1;
    end
  end

  function automatic logic [31:0] encodeReg(logic [5:0] op, int rd, int rs, int rt);
    return {op, 5'(rd), 5'(rs), 5'(rt), 11'd0};
  endfunction

  function automatic logic [31:0] encodeImm(logic [5:0] op, int rd, int rs, logic [15:0] imm);
    return {op, 5'(rd), 5'(rs), imm};
  endfunction

  // Expected ALU result by operation code
  function automatic logic [31:0] aluRef(logic [3:0] code, logic [31:0] a, logic [31:0] b);
    case (code)
      4'd2: return a + b;
      4'd3: return a - b;
      4'd4: return a | b;
      4'd5: return a & b;
      4'd6: return a ^ b;
      default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  task automatic appendInstr(logic [31:0] word);
    progMem[progLen] = word;
    progLen++;
  endtask

  task automatic buildProgram;
    for (int i = 0; i < 64; i++) begin
      progMem[i] = '0;
    end
    appendInstr(encodeImm(opLwi, 1, 0, 16'h0010));
    appendInstr(encodeImm(opLwi, 2, 0, 16'h0011));
    appendInstr(encodeImm(opLwi, 3, 0, 16'h0012));
    // R-type ADD through SLT
    for (int i = 0; i < 6; i++) begin
      appendInstr(encodeReg({2'b01, 4'(i + 2)}, 4, 1, 2 + i % 2));
      appendInstr(encodeImm(opSwi, 4, 0, 16'h0040 + 16'(i)));
    end
    // SLT with a negative and a positive constant
    appendInstr(encodeImm(opAddi, 5, 0, 16'hFFF9));
    appendInstr(encodeImm(opAddi, 8, 0, 16'h0009));
    appendInstr(encodeReg(opSlt, 4, 5, 8));
    appendInstr(encodeImm(opSwi, 4, 0, 16'h0046));
    appendInstr(encodeReg(opSlt, 4, 8, 5));
    appendInstr(encodeImm(opSwi, 4, 0, 16'h0047));
    // SLTI takes the small positive r8 so the sign of its immediate matters
    for (int i = 0; i < 6; i++) begin
      appendInstr(encodeImm({2'b11, 4'(i + 2)}, 4, (i == 5) ? 8 : 1 + i % 3,
                            immTable[i*16 +: 16]));
      appendInstr(encodeImm(opSwi, 4, 0, 16'h0050 + 16'(i)));
    end
    // Reload the XORI result and store it again
    appendInstr(encodeImm(opLwi, 9, 0, 16'h0054));
    appendInstr(32'h0);
    appendInstr(encodeImm(opSwi, 9, 0, 16'h0058));
    // Taken BEQ skips the first marker, untaken BEQ does not
    appendInstr(encodeImm(opBeq, 1, 1, 16'h0001));
    appendInstr(encodeImm(opSwi, 8, 0, 16'h0060));
    appendInstr(encodeImm(opSwi, 5, 0, 16'h0061));
    appendInstr(encodeImm(opBeq, 5, 8, 16'h0001));
    appendInstr(encodeImm(opSwi, 8, 0, 16'h0062));
    appendInstr(32'h0);
    appendInstr(encodeImm(opJ, 0, 0, 16'h0001));
    appendInstr(encodeImm(opSwi, 5, 0, skippedAddr));
    // Undefined opcode acts as NOP
    appendInstr({6'h3F, 26'd0});
    appendInstr(encodeImm(opSwi, 1, 0, 16'h0064));
    haltAddr = progLen;
    appendInstr(encodeImm(opJ, 0, 0, 16'hFFFF));
  endtask

  // Instruction-level model that records stores and the cycles between them
  task automatic runReferenceModel;
    logic [31:0] regs [32];
    logic [31:0] mem [dataWords];
    logic [31:0] word;
    logic [31:0] signImm;
    logic [31:0] zeroImm;
    logic [5:0]  op;
    logic [3:0]  code;
    logic        isAlu;
    int          pc;
    int          offset;
    int          rd;
    int          rs;
    int          rt;
    int          latency;
    int          cycles;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < dataWords; i++) begin
      mem[i] = dataMem[i];
    end
    pc = 0;
    cycles = 0;
    steps = 0;
    while (pc != haltAddr && steps < 1000) begin
      word    = progMem[pc];
      op      = word[31:26];
      code    = op[3:0];
      rd      = word[25:21];
      rs      = word[20:16];
      rt      = word[15:11];
      signImm = {{16{word[15]}}, word[15:0]};
      zeroImm = {16'd0, word[15:0]};
      offset  = $signed(word[15:0]);
      isAlu   = (code >= 4'd2 && code <= 4'd7);
      latency = 2;
      pc++;
      steps++;
      if (op[5:4] == 2'b01 && isAlu) begin
        regs[rd] = aluRef(code, regs[rs], regs[rt]);
        latency  = 4;
      end else if (op[5:4] == 2'b11 && isAlu) begin
        regs[rd] = aluRef(code, regs[rs], (code >= 4'd4 && code <= 4'd6) ? zeroImm : signImm);
        latency  = 4;
      end else if (op == opLwi) begin
        regs[rd] = mem[word[8:0]];
        latency  = 4;
      end else if (op == opSwi) begin
        mem[word[8:0]] = regs[rd];
        latency        = 4;
      end else if (op == opBeq) begin
        if (regs[rs] == regs[rd]) begin
          pc = pc + offset;
        end
        latency = 4;
      end else if (op == opJ) begin
        pc      = pc + offset;
        latency = 3;
      end
      cycles += latency;
      if (op == opSwi) begin
        expAddrList[expCount] = word[8:0];
        expDataList[expCount] = regs[rd];
        expGapList[expCount]  = cycles;
        expCount++;
        cycles = 0;
      end
    end
  endtask

  assert property (@(posedge clk) (cycleCount > 0 && (reset || resetDelayed)) |->
                   (!dataWrite && instrAddr == 0))
    else begin
      resetErrors++;
      $display("Fail at %0t: reset not held, dataWrite %b instrAddr %0h",
               $time, $sampled(dataWrite), $sampled(instrAddr));
    end

  assert property (@(posedge clk) disable iff (reset) dataWrite |-> storeIndex < expCount)
    else begin
      countErrors++;
      $display("Fail at %0t: extra store %0d to address %0h",
               $time, $sampled(storeIndex), $sampled(dataAddr));
    end

  assert property (@(posedge clk) disable iff (reset)
                   (dataWrite && storeIndex < expCount) |-> dataAddr == expAddr)
    else begin
      storeErrors++;
      $display("Fail at %0t: store %0d address %0h, expected %0h",
               $time, $sampled(storeIndex), $sampled(dataAddr), $sampled(expAddr));
    end

  assert property (@(posedge clk) disable iff (reset)
                   (dataWrite && storeIndex < expCount) |-> dataWriteData == expData)
    else begin
      storeErrors++;
      $display("Fail at %0t: store %0d data %08h, expected %08h",
               $time, $sampled(storeIndex), $sampled(dataWriteData), $sampled(expData));
    end

  // J must skip this marker
  assert property (@(posedge clk) disable iff (reset)
                   dataWrite |-> dataAddr != skippedAddr[8:0])
    else begin
      storeErrors++;
      $display("Fail at %0t: store to jumped-over address %0h", $time, $sampled(dataAddr));
    end

  assert property (@(posedge clk) disable iff (reset)
                   (dataWrite && storeIndex > 0 && storeIndex < expCount) |->
                   cycleCount - lastStoreCycle == expGap)
    else begin
      timingErrors++;
      $display("Fail at %0t: store %0d came %0d cycles after the previous one, expected %0d",
               $time, $sampled(storeIndex), $sampled(cycleCount) - $sampled(lastStoreCycle),
               $sampled(expGap));
    end

  assert property (@(posedge clk) disable iff (reset)
                   (instrAddr == haltAddr + 1 && !haltSeen) |-> storeIndex == expCount)
    else begin
      countErrors++;
      $display("Fail at %0t: %0d stores before halt, expected %0d",
               $time, $sampled(storeIndex), expCount);
    end

  initial begin
    void'($urandom(32'h4e1c8a4f));
    for (int i = 0; i < dataWords; i++) begin
      dataMem[i] = $urandom();
    end
    buildProgram();
    runReferenceModel();
    wait (haltSeen);
    @(posedge clk);
    $display("Errors: reset %0d, store %0d, timing %0d, count %0d (stores %0d of %0d)",
             resetErrors, storeErrors, timingErrors, countErrors, storeIndex, expCount);
    if (resetErrors + storeErrors + timingErrors + countErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Twice the worst-case time for the whole program
  initial begin
    wait (progLen > 0);
    #(progLen * 4 * periodNs * 2);
    $display("Timeout: the CPU never completed the program, %0d of %0d stores seen",
             storeIndex, expCount);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- registerFile.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module registerFile (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [`CPU_REG_ADDR_WIDTH-1:0]  readAddrA,
  input  logic [`CPU_REG_ADDR_WIDTH-1:0]  readAddrB,
  input  logic [`CPU_REG_ADDR_WIDTH-1:0]  writeAddr,
  input  logic [`CPU_WORD_WIDTH-1:0]      writeData,
  input  logic                            writeEnable,
  output logic [`CPU_WORD_WIDTH-1:0]      readDataA,
  output logic [`CPU_WORD_WIDTH-1:0]      readDataB
);

  logic [`CPU_WORD_WIDTH-1:0] regs [`CPU_REG_COUNT];

  // Reads are asynchronous
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

endmodule

//--- src.f
+incdir+.
cpuPkg.sv
controlFsm.sv
registerFile.sv
alu.sv
datapath.sv
multiCycleCpu.sv
tbClock.sv
multiCycleCpuTb.sv

//--- tbClock.sv
`timescale 1ns/100ps

module tbClock #(
  parameter int periodNs    = 40,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Release reset shortly after a rising edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule
